/* all.f */
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_regfile.sv
      - rv_execute.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;

  // RV32I major opcodes used by the encoders
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  localparam int          MEM_WORDS = 256;
  localparam int          BASE_IDX  = 64;
  localparam int          MAX_WAIT  = 1000;
  localparam logic [31:0] MARKER    = 32'hdead_beef;

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;
  logic        ebreak;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] prog [$];
  int          prog_len;
  integer      seed;

  // --------------------------------------------------
  // Zero-latency memory model
  // --------------------------------------------------
  // Misaligned fetches and fetches past the loaded program return EBREAK
  assign imem_rdata = (imem_addr[1:0] == 2'b00 && imem_addr[31:2] < prog_len) ?
                      imem[imem_addr[9:2]] : `RV_EBREAK;
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  rv_core i_dut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_rdata(dmem_rdata),
    .ebreak    (ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Word store only
  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // --------------------------------------------------
  // Reference behavior from the ISA
  // --------------------------------------------------
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        // Arithmetic shift fills the vacated upper bits with the sign
        if (alt) begin
          return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'hf00d_0000 | 32'(idx);
  endfunction

  // --------------------------------------------------
  // Program building and run control
  // --------------------------------------------------
  task automatic emit(input logic [31:0] instr);
    prog.push_back(instr);
  endtask

  // LUI plus ADDI with the upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, OPC_LUI));
    emit(i_type(value[11:0], rd, 3'd0, rd, OPC_OP_IMM));
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("Mismatch at %0t ns: %s got %08h, expected %08h",
                         $time, what, got, exp));
    end
  endtask

  // Clears data memory and starts a program with x3 = 0x100
  task automatic start_program();
    prog.delete();
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i] = fill_word(i);
    end
    emit(i_type(12'h100, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
      assert (imem_addr === `RV_RESET_PC && dmem_we === 1'b0 && ebreak === 1'b0) else begin
        fail_now($sformatf("Mismatch at %0t ns: reset state pc %08h we %b ebreak %b",
                           $time, imem_addr, dmem_we, ebreak));
      end
    end
    reset = 1'b0;
  endtask

  task automatic run_program();
    int          cycles;
    logic [31:0] halt_pc;
    emit(`RV_EBREAK);
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end
    prog_len = prog.size();
    apply_reset();
    cycles = 0;
    while (ebreak !== 1'b1 && cycles < MAX_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (ebreak === 1'b1) else begin
      fail_now("Error: the core did not halt within 1000 cycles");
    end
    // Halted core keeps its PC and never writes
    halt_pc = imem_addr;
    repeat (20) begin
      @(posedge clk);
      #1;
      assert (imem_addr === halt_pc && dmem_we === 1'b0 && ebreak === 1'b1) else begin
        fail_now($sformatf("Mismatch at %0t ns: after halt pc %08h we %b ebreak %b",
                           $time, imem_addr, dmem_we, ebreak));
      end
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_alu_ops();
    logic [2:0]  op_f3  [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
    logic        op_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [11:0] imm    [10];
    logic [31:0] a;
    logic [31:0] b;
    start_program();
    a = $random(seed);
    b = $random(seed);
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      emit(r_type(op_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, op_f3[k], 5'd4));
      emit(s_type(12'(4 * k), 5'd4, 5'd3));
      imm[k] = $random(seed);
      // Shifts carry shamt and the arithmetic bit in the immediate
      if (op_f3[k] == 3'd1 || op_f3[k] == 3'd5) begin
        imm[k] = {1'b0, op_alt[k], 5'b0, imm[k][4:0]};
      end
      // No SUBI in RV32I
      if (k != 1) begin
        emit(i_type(imm[k], 5'd1, op_f3[k], 5'd5, OPC_OP_IMM));
        emit(s_type(12'(40 + 4 * k), 5'd5, 5'd3));
      end
    end
    run_program();
    for (int k = 0; k < 10; k++) begin
      check_word($sformatf("register op %0d", k), dmem[BASE_IDX + k],
                 ref_alu(op_f3[k], op_alt[k], a, b));
      if (k != 1) begin
        check_word($sformatf("immediate op %0d", k), dmem[BASE_IDX + 10 + k],
                   ref_alu(op_f3[k], op_alt[k], a, {{20{imm[k][11]}}, imm[k]}));
      end
    end
  endtask

  task automatic test_upper_imm();
    logic [19:0] u_lui;
    logic [19:0] u_auipc;
    logic [31:0] auipc_pc;
    start_program();
    u_lui   = $random(seed);
    u_auipc = $random(seed);
    emit(u_type(u_lui, 5'd5, OPC_LUI));
    emit(s_type(12'd0, 5'd5, 5'd3));
    auipc_pc = 32'(prog.size() * 4);
    emit(u_type(u_auipc, 5'd6, OPC_AUIPC));
    emit(s_type(12'd4, 5'd6, 5'd3));
    run_program();
    check_word("LUI result", dmem[BASE_IDX], {u_lui, 12'b0});
    check_word("AUIPC result", dmem[BASE_IDX + 1], {u_auipc, 12'b0} + auipc_pc);
  endtask

  task automatic test_load_store();
    logic [31:0] words [4];
    logic [11:0] incr  [4];
    start_program();
    for (int k = 0; k < 4; k++) begin
      words[k] = $random(seed);
      incr[k]  = $random(seed);
      dmem[BASE_IDX + k] = words[k];
      emit(i_type(12'(4 * k), 5'd3, 3'b010, 5'd7, OPC_LOAD));
      emit(i_type(incr[k], 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
      emit(s_type(12'(64 + 4 * k), 5'd7, 5'd3));
    end
    run_program();
    for (int k = 0; k < 4; k++) begin
      check_word($sformatf("load/store word %0d", k), dmem[BASE_IDX + 16 + k],
                 words[k] + {{20{incr[k][11]}}, incr[k]});
    end
  endtask

  task automatic test_control_flow();
    logic [2:0]  conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] neg_val;
    logic [31:0] pos_val;
    logic [31:0] jal_pc;
    logic [31:0] jalr_pc;
    int          slot;
    int          n;
    start_program();
    neg_val = $random(seed) | 32'h8000_0000;
    pos_val = $random(seed) & 32'h7fff_ffff;
    load_const(5'd10, neg_val);
    load_const(5'd11, pos_val);
    load_const(5'd20, MARKER);
    slot = 0;
    // Operand pairs (x10,x10), (x10,x11), (x11,x10) give taken and not-taken cases
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        emit(b_type(13'd8, (p == 1) ? 5'd11 : 5'd10, (p == 2) ? 5'd11 : 5'd10, conds[c]));
        if (!ref_branch(conds[c], (p == 2) ? pos_val : neg_val,
                        (p == 1) ? pos_val : neg_val)) begin
          emit(j_type(21'd8, 5'd0));
        end
        emit(s_type(12'(4 * slot), 5'd20, 5'd3));
        slot++;
      end
    end
    jal_pc = 32'(prog.size() * 4);
    emit(j_type(21'd8, 5'd12));
    emit(s_type(12'd72, 5'd20, 5'd3));
    emit(s_type(12'd80, 5'd12, 5'd3));
    // Odd JALR base whose bit 0 the core must drop from the target
    n = prog.size();
    emit(i_type(12'((n + 3) * 4 + 1), 5'd0, 3'd0, 5'd13, OPC_OP_IMM));
    jalr_pc = 32'(prog.size() * 4);
    emit(i_type(12'd0, 5'd13, 3'd0, 5'd14, OPC_JALR));
    emit(s_type(12'd76, 5'd20, 5'd3));
    emit(s_type(12'd84, 5'd14, 5'd3));
    run_program();
    for (int s = 0; s < 20; s++) begin
      check_word($sformatf("wrong-path slot %0d", s), dmem[BASE_IDX + s],
                 fill_word(BASE_IDX + s));
    end
    check_word("JAL link", dmem[BASE_IDX + 20], jal_pc + 32'd4);
    check_word("JALR link", dmem[BASE_IDX + 21], jalr_pc + 32'd4);
  endtask

  initial begin
    seed     = 32'hc9e40a0f;
    reset    = 1'b1;
    prog_len = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i] = fill_word(i);
    end
    test_alu_ops();
    test_upper_imm();
    test_load_store();
    test_control_flow();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core (
  input  logic                clk,
  input  logic                reset,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [31:0]         imem_rdata,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic                dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                ebreak
);

  // Fetch
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic                instr_valid;
  logic                halted;

  // Decode
  logic [4:0]           rs1_addr;
  logic [4:0]           rs2_addr;
  logic [4:0]           rd_addr;
  logic [`RV_XLEN-1:0]  imm;
  rv_pkg::alu_op_e      alu_op;
  rv_pkg::alu_a_src_e   alu_a_src;
  rv_pkg::alu_b_src_e   alu_b_src;
  rv_pkg::res_src_e     res_src;
  rv_pkg::branch_cond_e branch_cond;
  logic                 reg_write;
  logic                 mem_write;
  logic                 is_branch;
  logic                 is_jump;
  logic                 is_jalr;
  logic                 is_ebreak;

  // Register file and execute
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] rd_data;
  logic [`RV_XLEN-1:0] jb_target;
  logic                pc_sel;

  // --------------------------------------------------
  // Fetch and decode
  // --------------------------------------------------
  rv_fetch i_fetch (
    .clk        (clk),
    .reset      (reset),
    .pc_sel     (pc_sel),
    .jb_target  (jb_target),
    .is_ebreak  (is_ebreak),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .instr_valid(instr_valid),
    .halted     (halted)
  );

  rv_decode i_decode (
    .instr      (imem_rdata),
    .instr_valid(instr_valid),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rd_addr    (rd_addr),
    .imm        (imm),
    .alu_op     (alu_op),
    .alu_a_src  (alu_a_src),
    .alu_b_src  (alu_b_src),
    .res_src    (res_src),
    .branch_cond(branch_cond),
    .reg_write  (reg_write),
    .mem_write  (mem_write),
    .is_branch  (is_branch),
    .is_jump    (is_jump),
    .is_jalr    (is_jalr),
    .is_ebreak  (is_ebreak)
  );

  // --------------------------------------------------
  // Register file and execute
  // --------------------------------------------------
  rv_regfile i_regfile (
    .clk     (clk),
    .reset   (reset),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rd_addr (rd_addr),
    .rd_en   (reg_write),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv_execute i_execute (
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .dmem_rdata (dmem_rdata),
    .alu_op     (alu_op),
    .alu_a_src  (alu_a_src),
    .alu_b_src  (alu_b_src),
    .res_src    (res_src),
    .branch_cond(branch_cond),
    .is_branch  (is_branch),
    .is_jump    (is_jump),
    .is_jalr    (is_jalr),
    .alu_result (alu_result),
    .rd_data    (rd_data),
    .jb_target  (jb_target),
    .pc_sel     (pc_sel)
  );

  // Zero-latency memory ports
  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = mem_write;
  assign ebreak     = halted;

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_execute (
  input  logic                 [`RV_XLEN-1:0] pc,
  input  logic                 [`RV_XLEN-1:0] pc_plus4,
  input  logic                 [`RV_XLEN-1:0] rs1_data,
  input  logic                 [`RV_XLEN-1:0] rs2_data,
  input  logic                 [`RV_XLEN-1:0] imm,
  input  logic                 [`RV_XLEN-1:0] dmem_rdata,
  input  rv_pkg::alu_op_e                     alu_op,
  input  rv_pkg::alu_a_src_e                  alu_a_src,
  input  rv_pkg::alu_b_src_e                  alu_b_src,
  input  rv_pkg::res_src_e                    res_src,
  input  rv_pkg::branch_cond_e                branch_cond,
  input  logic                                is_branch,
  input  logic                                is_jump,
  input  logic                                is_jalr,
  output logic                 [`RV_XLEN-1:0] alu_result,
  output logic                 [`RV_XLEN-1:0] rd_data,
  output logic                 [`RV_XLEN-1:0] jb_target,
  output logic                                pc_sel
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [SHAMT_W-1:0]  shamt;
  logic                rs_eq;
  logic                rs_lt;
  logic                rs_ltu;
  logic                branch_taken;
  logic [`RV_XLEN-1:0] pc_rel_target;

  // --------------------------------------------------
  // Operands and ALU
  // --------------------------------------------------
  always_comb begin
    case (alu_a_src)
      rv_pkg::A_PC:   alu_a = pc;
      rv_pkg::A_ZERO: alu_a = '0;
      default:        alu_a = rs1_data;
    endcase
  end

  assign alu_b = (alu_b_src == rv_pkg::B_IMM) ? imm : rs2_data;
  assign shamt = alu_b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    alu_result = alu_a + alu_b;
      rv_pkg::ALU_SUB:    alu_result = alu_a - alu_b;
      rv_pkg::ALU_AND:    alu_result = alu_a & alu_b;
      rv_pkg::ALU_OR:     alu_result = alu_a | alu_b;
      rv_pkg::ALU_XOR:    alu_result = alu_a ^ alu_b;
      rv_pkg::ALU_SLT:    alu_result = `RV_XLEN'($signed(alu_a) < $signed(alu_b));
      rv_pkg::ALU_SLTU:   alu_result = `RV_XLEN'(alu_a < alu_b);
      rv_pkg::ALU_SLL:    alu_result = alu_a << shamt;
      rv_pkg::ALU_SRL:    alu_result = alu_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = $unsigned($signed(alu_a) >>> shamt);
      rv_pkg::ALU_PASS_B: alu_result = alu_b;
      default:            alu_result = '0;
    endcase
  end

  // --------------------------------------------------
  // Branch compare and target
  // --------------------------------------------------
  assign rs_eq  = (rs1_data == rs2_data);
  assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign rs_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (branch_cond)
      rv_pkg::BR_EQ:  branch_taken = rs_eq;
      rv_pkg::BR_NE:  branch_taken = !rs_eq;
      rv_pkg::BR_LT:  branch_taken = rs_lt;
      rv_pkg::BR_GE:  branch_taken = !rs_lt;
      rv_pkg::BR_LTU: branch_taken = rs_ltu;
      rv_pkg::BR_GEU: branch_taken = !rs_ltu;
      default:        branch_taken = 1'b0;
    endcase
  end

  assign pc_sel = (is_branch && branch_taken) || is_jump;

  // JALR clears bit 0 of rs1 + imm
  assign pc_rel_target = pc + imm;
  assign jb_target     = is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc_rel_target;

  // Writeback select
  always_comb begin
    case (res_src)
      rv_pkg::RES_LOAD: rd_data = dmem_rdata;
      rv_pkg::RES_PC4:  rd_data = pc_plus4;
      default:          rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                reset,
  input  logic [4:0]          rs1_addr,
  input  logic [4:0]          rs2_addr,
  input  logic [4:0]          rd_addr,
  input  logic                rd_en,
  input  logic [`RV_XLEN-1:0] rd_data,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_decode (
  input  logic                 [31:0]         instr,
  input  logic                                instr_valid,
  output logic                 [4:0]          rs1_addr,
  output logic                 [4:0]          rs2_addr,
  output logic                 [4:0]          rd_addr,
  output logic                 [`RV_XLEN-1:0] imm,
  output rv_pkg::alu_op_e                     alu_op,
  output rv_pkg::alu_a_src_e                  alu_a_src,
  output rv_pkg::alu_b_src_e                  alu_b_src,
  output rv_pkg::res_src_e                    res_src,
  output rv_pkg::branch_cond_e                branch_cond,
  output logic                                reg_write,
  output logic                                mem_write,
  output logic                                is_branch,
  output logic                                is_jump,
  output logic                                is_jalr,
  output logic                                is_ebreak
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic                funct7_b5;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  rv_pkg::alu_op_e     arith_op;
  logic                reg_write_dec;
  logic                mem_write_dec;
  logic                is_branch_dec;
  logic                is_jump_dec;
  logic                is_jalr_dec;

  // --------------------------------------------------
  // Fields and immediates
  // --------------------------------------------------
  assign opcode    = rv_pkg::opcode_e'(instr[6:0]);
  assign rd_addr   = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1_addr  = instr[19:15];
  assign rs2_addr  = instr[24:20];
  assign funct7_b5 = instr[30];

  assign imm_i = {{(`RV_XLEN-11){instr[31]}}, instr[30:20]};
  assign imm_s = {{(`RV_XLEN-11){instr[31]}}, instr[30:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-31){instr[31]}}, instr[30:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  assign branch_cond = rv_pkg::branch_cond_e'(funct3);

  // --------------------------------------------------
  // ALU op from funct3 and funct7
  // --------------------------------------------------
  always_comb begin
    case (funct3)
      // SUB exists only in the register form
      3'b000: begin
        arith_op = (opcode == rv_pkg::OPC_OP && funct7_b5) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      end
      3'b001: arith_op = rv_pkg::ALU_SLL;
      3'b010: arith_op = rv_pkg::ALU_SLT;
      3'b011: arith_op = rv_pkg::ALU_SLTU;
      3'b100: arith_op = rv_pkg::ALU_XOR;
      3'b101: arith_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110: arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  end

  // --------------------------------------------------
  // Control decode
  // --------------------------------------------------
  always_comb begin
    imm           = imm_i;
    alu_op        = rv_pkg::ALU_ADD;
    alu_a_src     = rv_pkg::A_RS1;
    alu_b_src     = rv_pkg::B_IMM;
    res_src       = rv_pkg::RES_ALU;
    reg_write_dec = 1'b0;
    mem_write_dec = 1'b0;
    is_branch_dec = 1'b0;
    is_jump_dec   = 1'b0;
    is_jalr_dec   = 1'b0;

    case (opcode)
      rv_pkg::OPC_OP: begin
        alu_op        = arith_op;
        alu_b_src     = rv_pkg::B_RS2;
        reg_write_dec = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        alu_op        = arith_op;
        reg_write_dec = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        imm           = imm_u;
        alu_op        = rv_pkg::ALU_PASS_B;
        alu_a_src     = rv_pkg::A_ZERO;
        reg_write_dec = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        imm           = imm_u;
        alu_a_src     = rv_pkg::A_PC;
        reg_write_dec = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        imm           = imm_j;
        res_src       = rv_pkg::RES_PC4;
        reg_write_dec = 1'b1;
        is_jump_dec   = 1'b1;
      end
      // Target comes from the ALU sum rs1 + imm
      rv_pkg::OPC_JALR: begin
        res_src       = rv_pkg::RES_PC4;
        reg_write_dec = 1'b1;
        is_jump_dec   = 1'b1;
        is_jalr_dec   = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        imm           = imm_b;
        is_branch_dec = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        res_src       = rv_pkg::RES_LOAD;
        reg_write_dec = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        imm           = imm_s;
        mem_write_dec = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // No side effects from an invalid slot
  assign reg_write = instr_valid && reg_write_dec;
  assign mem_write = instr_valid && mem_write_dec;
  assign is_branch = instr_valid && is_branch_dec;
  assign is_jump   = instr_valid && is_jump_dec;
  assign is_jalr   = instr_valid && is_jalr_dec;
  assign is_ebreak = instr_valid && (instr == `RV_EBREAK);

endmodule

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                pc_sel,
  input  logic [`RV_XLEN-1:0] jb_target,
  input  logic                is_ebreak,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4,
  output logic                instr_valid,
  output logic                halted
);

  logic [`RV_XLEN-1:0] pc_next;

  assign pc_plus4 = pc + `RV_XLEN'(4);
  assign pc_next  = pc_sel ? jb_target : pc_plus4;

  // PC moves only when a valid instruction other than EBREAK retires
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else if (instr_valid && !is_ebreak) begin
      pc <= pc_next;
    end
  end

  // One idle cycle after reset, then run until EBREAK
  always_ff @(posedge clk) begin
    if (reset) begin
      instr_valid <= 1'b0;
      halted      <= 1'b0;
    end else if (instr_valid && is_ebreak) begin
      instr_valid <= 1'b0;
      halted      <= 1'b1;
    end else if (!halted) begin
      instr_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } alu_a_src_e;

  typedef enum logic {
    B_RS2,
    B_IMM
  } alu_b_src_e;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_LOAD,
    RES_PC4
  } res_src_e;

  // Same encoding as funct3 of the branch instructions
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

endpackage

`default_nettype wire

/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers x0 to x31
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// SYSTEM opcode with imm 1, all other fields zero
`define RV_EBREAK 32'h0010_0073

`endif
